//--- dsp_params.svh
// DSP core size parameters
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

// Data path
`define DSP_WORD_W      16
`define DSP_ACC_W       36

// Data RAM, 256 words
`define DSP_RAM_AW      8
`define DSP_RAM_DEPTH   (1 << `DSP_RAM_AW)

// Program ROM, 256 words
`define DSP_ROM_AW      8
`define DSP_ROM_DEPTH   (1 << `DSP_ROM_AW)

// Byte address for ROM programming, low byte at even address
`define DSP_PROG_AW     9

// Instruction immediate field
`define DSP_IMM_W       8

`endif

//--- dsp_pkg.sv
// DSP core shared types
`include "dsp_params.svh"

package dsp_pkg;

    typedef logic [`DSP_WORD_W-1:0]  word_t;
    typedef logic [`DSP_ACC_W-1:0]   acc_t;
    typedef logic [`DSP_RAM_AW-1:0]  ram_addr_t;
    typedef logic [`DSP_ROM_AW-1:0]  rom_addr_t;
    typedef logic [`DSP_PROG_AW-1:0] prog_addr_t;
    typedef logic [`DSP_IMM_W-1:0]   imm_t;

    // Instruction bits 15..12
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDAI = 4'h1,
        OP_SETX = 4'h2,
        OP_SETR = 4'h3,
        OP_LDA  = 4'h4,
        OP_STA  = 4'h5,
        OP_MAC  = 4'h6,
        OP_OUT  = 4'h7,
        OP_GOTO = 4'h8
    } opcode_e;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_WAIT,
        HALT
    } seq_state_e;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        ram_addr_t adr;
        word_t     dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // Sequencer to DAU
    typedef struct packed {
        opcode_e op;
        logic    exec;
        imm_t    imm;
        word_t   ram_dat;   // operand for LDA and MAC
    } dau_ctrl_t;

endpackage

//--- dsp_rom.sv
// Program ROM
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_rom (
    input  logic                clk,
    input  dsp_pkg::prog_addr_t prog_addr,
    input  logic [7:0]          prog_data,
    input  logic                prog_we,
    input  dsp_pkg::rom_addr_t  addr,
    output dsp_pkg::word_t      dout
);
    import dsp_pkg::*;

    logic [7:0] mem_lo [`DSP_ROM_DEPTH];
    logic [7:0] mem_hi [`DSP_ROM_DEPTH];
    rom_addr_t  prog_word;

    assign prog_word = prog_addr[`DSP_PROG_AW-1:1];

    // One byte per write, bit 0 picks the half
    always_ff @(posedge clk) begin
        if (prog_we && !prog_addr[0]) begin
            mem_lo[prog_word] <= prog_data;
        end
        if (prog_we && prog_addr[0]) begin
            mem_hi[prog_word] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        dout <= {mem_hi[addr], mem_lo[addr]};
    end

endmodule

//--- dsp_seq.sv
// Instruction sequencer
`timescale 1ns/10ps

module dsp_seq (
    input  logic                clk,
    input  logic                reset,
    input  dsp_pkg::word_t      rom_dout,
    output dsp_pkg::rom_addr_t  pc,
    output dsp_pkg::wb_req_t    core_req,
    input  dsp_pkg::wb_rsp_t    core_rsp,
    input  dsp_pkg::ram_addr_t  ptr_addr,
    input  dsp_pkg::word_t      store_dat,
    output logic [1:0]          ptr_sel,
    output logic                ptr_load,
    output logic                ptr_inc,
    output dsp_pkg::imm_t       imm,
    output dsp_pkg::dau_ctrl_t  dau_ctrl,
    output logic                fault
);
    import dsp_pkg::*;

    seq_state_e state;
    word_t      ir;
    word_t      instr;
    opcode_e    op;
    logic       op_valid;
    logic       op_mem;
    logic       simple_done;
    logic       mem_done;

    // ROM word is valid in EXEC, held in ir while the RAM access runs
    assign instr = (state == MEM_WAIT) ? ir : rom_dout;
    assign op    = opcode_e'(instr[15:12]);

    always_comb begin
        op_valid = 1'b0;
        op_mem   = 1'b0;
        case (op)
            OP_NOP, OP_LDAI, OP_SETX, OP_SETR, OP_OUT, OP_GOTO: begin
                op_valid = 1'b1;
            end
            OP_LDA, OP_STA, OP_MAC: begin
                op_valid = 1'b1;
                op_mem   = 1'b1;
            end
            default: begin
                op_valid = 1'b0;
            end
        endcase
    end

    assign simple_done = (state == EXEC) && op_valid && !op_mem;
    assign mem_done    = (state == MEM_WAIT) && core_rsp.ack;

    // Pointer unit control
    assign ptr_sel  = instr[11:10];
    assign imm      = instr[7:0];
    assign ptr_load = (state == EXEC) && (op == OP_SETR);
    assign ptr_inc  = mem_done && instr[9];

    always_comb begin
        dau_ctrl.op      = op;
        dau_ctrl.exec    = simple_done || mem_done;
        dau_ctrl.imm     = imm;
        dau_ctrl.ram_dat = core_rsp.dat;
    end

    always_ff @(posedge clk) begin
        if (state == EXEC) begin
            ir <= rom_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH;
            pc       <= '0;
            fault    <= 1'b0;
            core_req <= '0;
        end else begin
            case (state)
                FETCH: begin
                    state <= EXEC;
                end
                EXEC: begin
                    if (!op_valid) begin
                        fault <= 1'b1;
                        state <= HALT;
                    end else if (op_mem) begin
                        // Start the bus cycle, held until ack
                        core_req.cyc <= 1'b1;
                        core_req.stb <= 1'b1;
                        core_req.we  <= (op == OP_STA);
                        core_req.adr <= ptr_addr;
                        core_req.dat <= store_dat;
                        state        <= MEM_WAIT;
                    end else begin
                        pc    <= (op == OP_GOTO) ? rom_addr_t'(imm) : pc + 1'b1;
                        state <= FETCH;
                    end
                end
                MEM_WAIT: begin
                    if (core_rsp.ack) begin
                        core_req.cyc <= 1'b0;
                        core_req.stb <= 1'b0;
                        pc           <= pc + 1'b1;
                        state        <= FETCH;
                    end
                end
                HALT: begin
                    // Only reset gets out of here
                    state <= HALT;
                end
                default: begin
                    state <= HALT;
                end
            endcase
        end
    end

endmodule

//--- dsp_ram_aau.sv
// RAM address unit
`timescale 1ns/10ps

module dsp_ram_aau (
    input  logic               clk,
    input  logic               reset,
    input  logic [1:0]         ptr_sel,
    input  logic               ptr_load,
    input  logic               ptr_inc,
    input  dsp_pkg::imm_t      imm,
    output dsp_pkg::ram_addr_t ptr_addr
);
    import dsp_pkg::*;

    // Pointers r0 to r3
    ram_addr_t r_reg [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            r_reg <= '{default: '0};
        end else if (ptr_load) begin
            r_reg[ptr_sel] <= ram_addr_t'(imm);
        end else if (ptr_inc) begin
            // Wraps at 8 bits
            r_reg[ptr_sel] <= r_reg[ptr_sel] + 1'b1;
        end
    end

    assign ptr_addr = r_reg[ptr_sel];

endmodule

//--- dsp_dau.sv
// Data arithmetic unit
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_dau (
    input  logic               clk,
    input  logic               reset,
    input  dsp_pkg::dau_ctrl_t dau_ctrl,
    output dsp_pkg::word_t     a0_low,
    output dsp_pkg::word_t     pbus_out,
    output logic               pods_n
);
    import dsp_pkg::*;

    word_t x;
    acc_t  a0;
    word_t imm_word;
    acc_t  imm_acc;
    acc_t  ram_acc;
    acc_t  prod_acc;
    logic signed [2*`DSP_WORD_W-1:0] prod;

    // Sign extension of the operands
    assign imm_word = {{(`DSP_WORD_W-`DSP_IMM_W){dau_ctrl.imm[`DSP_IMM_W-1]}}, dau_ctrl.imm};
    assign imm_acc  = {{(`DSP_ACC_W-`DSP_IMM_W){dau_ctrl.imm[`DSP_IMM_W-1]}}, dau_ctrl.imm};
    assign ram_acc  = {{(`DSP_ACC_W-`DSP_WORD_W){dau_ctrl.ram_dat[`DSP_WORD_W-1]}},
                       dau_ctrl.ram_dat};

    // Signed 16x16 product
    assign prod     = $signed(x) * $signed(dau_ctrl.ram_dat);
    assign prod_acc = {{(`DSP_ACC_W-2*`DSP_WORD_W){prod[2*`DSP_WORD_W-1]}}, prod};

    assign a0_low = a0[`DSP_WORD_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            x        <= '0;
            a0       <= '0;
            pbus_out <= '0;
            pods_n   <= 1'b1;
        end else begin
            pods_n <= 1'b1;
            if (dau_ctrl.exec) begin
                case (dau_ctrl.op)
                    OP_LDAI: a0 <= imm_acc;
                    OP_SETX: x  <= imm_word;
                    OP_LDA:  a0 <= ram_acc;
                    OP_MAC:  a0 <= a0 + prod_acc;
                    OP_OUT: begin
                        pbus_out <= a0_low;
                        pods_n   <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- dsp_ram_arbiter.sv
// Two-master RAM arbiter
`timescale 1ns/10ps

module dsp_ram_arbiter (
    input  logic             clk,
    input  logic             reset,
    input  dsp_pkg::wb_req_t m0_req,
    input  dsp_pkg::wb_req_t m1_req,
    output dsp_pkg::wb_rsp_t m0_rsp,
    output dsp_pkg::wb_rsp_t m1_rsp,
    output dsp_pkg::wb_req_t s_req,
    input  dsp_pkg::wb_rsp_t s_rsp
);
    import dsp_pkg::*;

    logic    busy;
    logic    owner;     // current owner, and last winner once idle
    logic    m0_want;
    logic    m1_want;
    logic    pick;
    wb_req_t cur_req;

    assign m0_want = m0_req.cyc && m0_req.stb;
    assign m1_want = m1_req.cyc && m1_req.stb;

    // Tie goes to the master that lost last time
    assign pick    = (m0_want && m1_want) ? ~owner : m1_want;
    assign cur_req = owner ? m1_req : m0_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= 1'b1;
        end else if (!busy) begin
            if (m0_want || m1_want) begin
                busy  <= 1'b1;
                owner <= pick;
            end
        end else if (!cur_req.cyc) begin
            // Owner closed its cycle
            busy <= 1'b0;
        end
    end

    always_comb begin
        s_req      = busy ? cur_req : '0;
        m0_rsp.dat = s_rsp.dat;
        m0_rsp.ack = busy && !owner && s_rsp.ack;
        m1_rsp.dat = s_rsp.dat;
        m1_rsp.ack = busy && owner && s_rsp.ack;
    end

endmodule

//--- dsp_ram.sv
// Data RAM with Wishbone slave port
`timescale 1ns/10ps
`include "dsp_params.svh"

module dsp_ram (
    input  logic             clk,
    input  logic             reset,
    input  dsp_pkg::wb_req_t req,
    output dsp_pkg::wb_rsp_t rsp
);
    import dsp_pkg::*;

    word_t mem [`DSP_RAM_DEPTH];
    word_t dat_q;
    logic  ack_q;
    logic  access;

    // No second access while the ack is out
    assign access = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req.we) begin
                mem[req.adr] <= req.dat;
            end
            dat_q <= mem[req.adr];
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = dat_q;

endmodule

//--- dsp_core_top.sv
// DSP core top level
`timescale 1ns/10ps

module dsp_core_top (
    input  logic                clk,
    input  logic                reset,
    input  dsp_pkg::prog_addr_t prog_addr,
    input  logic [7:0]          prog_data,
    input  logic                prog_we,
    input  dsp_pkg::wb_req_t    host_req,
    output dsp_pkg::wb_rsp_t    host_rsp,
    output dsp_pkg::word_t      pbus_out,
    output logic                pods_n,
    output logic                fault
);
    import dsp_pkg::*;

    rom_addr_t pc;
    word_t     rom_dout;
    wb_req_t   core_req;
    wb_rsp_t   core_rsp;
    wb_req_t   ram_req;
    wb_rsp_t   ram_rsp;
    ram_addr_t ptr_addr;
    word_t     a0_low;
    logic [1:0] ptr_sel;
    logic      ptr_load;
    logic      ptr_inc;
    imm_t      imm;
    dau_ctrl_t dau_ctrl;

    dsp_rom u_rom (
        .clk        ( clk         ),
        .prog_addr  ( prog_addr   ),
        .prog_data  ( prog_data   ),
        .prog_we    ( prog_we     ),
        .addr       ( pc          ),
        .dout       ( rom_dout    )
    );

    dsp_seq u_seq (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .rom_dout   ( rom_dout    ),
        .pc         ( pc          ),
        .core_req   ( core_req    ),
        .core_rsp   ( core_rsp    ),
        .ptr_addr   ( ptr_addr    ),
        .store_dat  ( a0_low      ),
        .ptr_sel    ( ptr_sel     ),
        .ptr_load   ( ptr_load    ),
        .ptr_inc    ( ptr_inc     ),
        .imm        ( imm         ),
        .dau_ctrl   ( dau_ctrl    ),
        .fault      ( fault       )
    );

    dsp_ram_aau u_ram_aau (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .ptr_sel    ( ptr_sel     ),
        .ptr_load   ( ptr_load    ),
        .ptr_inc    ( ptr_inc     ),
        .imm        ( imm         ),
        .ptr_addr   ( ptr_addr    )
    );

    dsp_dau u_dau (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .dau_ctrl   ( dau_ctrl    ),
        .a0_low     ( a0_low      ),
        .pbus_out   ( pbus_out    ),
        .pods_n     ( pods_n      )
    );

    // Core is master 0, host is master 1
    dsp_ram_arbiter u_arbiter (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .m0_req     ( core_req    ),
        .m1_req     ( host_req    ),
        .m0_rsp     ( core_rsp    ),
        .m1_rsp     ( host_rsp    ),
        .s_req      ( ram_req     ),
        .s_rsp      ( ram_rsp     )
    );

    dsp_ram u_ram (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .req        ( ram_req     ),
        .rsp        ( ram_rsp     )
    );

endmodule

//--- tb_dsp_core_assertions.sv
// DSP core protocol assertions
`timescale 1ns/10ps

module tb_dsp_core_assertions (
    input logic             clk,
    input logic             reset,
    input dsp_pkg::word_t   pbus_out,
    input logic             pods_n,
    input logic             fault,
    input dsp_pkg::wb_req_t host_req,
    input dsp_pkg::wb_rsp_t host_rsp,
    input dsp_pkg::wb_req_t core_req
);
    int unsigned fail_count = 0;

    // Output strobe is a single-cycle pulse
    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        !pods_n |=> pods_n)
    else begin
        $error("pods_n held low for more than one cycle");
        fail_count++;
    end

    pbus_stable: assert property (@(posedge clk) disable iff (reset)
        pods_n |-> $stable(pbus_out))
    else begin
        $error("pbus_out changed without a pods_n strobe");
        fail_count++;
    end

    // Host only gets an ack inside its own strobe
    host_ack_in_stb: assert property (@(posedge clk) disable iff (reset)
        host_rsp.ack |-> host_req.stb)
    else begin
        $error("host_rsp.ack without host_req.stb");
        fail_count++;
    end

    fault_sticky: assert property (@(posedge clk) disable iff (reset)
        $fell(fault) |-> $past(reset))
    else begin
        $error("fault fell outside reset");
        fail_count++;
    end

    reset_state: assert property (@(posedge clk)
        reset |=> (pods_n && !fault && !host_rsp.ack && !core_req.cyc && !core_req.stb))
    else begin
        $error("outputs not in their reset state after reset");
        fail_count++;
    end

endmodule

bind dsp_core_top tb_dsp_core_assertions u_assertions (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .pbus_out ( pbus_out ),
    .pods_n   ( pods_n   ),
    .fault    ( fault    ),
    .host_req ( host_req ),
    .host_rsp ( host_rsp ),
    .core_req ( core_req )
);

//--- tb_dsp_core.sv
// DSP core testbench
`timescale 1ns/10ps
`include "dsp_params.svh"

module tb_dsp_core;
    import dsp_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int RUN_LIMIT  = 1000;

    logic       clk;
    logic       reset;
    prog_addr_t prog_addr;
    logic [7:0] prog_data;
    logic       prog_we;
    wb_req_t    host_req;
    wb_rsp_t    host_rsp;
    word_t      pbus_out;
    logic       pods_n;
    logic       fault;

    word_t       prog [$];
    word_t       exp_outs [$];
    word_t       model_ram [`DSP_RAM_DEPTH];
    logic [31:0] rng;
    int          errors;
    int          timeouts;
    int          pulses;

    dsp_core_top u_dut (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .host_req  ( host_req  ),
        .host_rsp  ( host_rsp  ),
        .pbus_out  ( pbus_out  ),
        .pods_n    ( pods_n    ),
        .fault     ( fault     )
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic word_t encode(input opcode_e op, input logic [1:0] sel,
                                     input logic inc, input imm_t imm);
        return {op, sel, inc, 1'b0, imm};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        int fails;
        fails = u_dut.u_assertions.fail_count;
        $display("Errors: %0d value, %0d timeout, %0d assertion", errors, timeouts, fails);
        if (errors == 0 && timeouts == 0 && fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Instruction set model that stops at the first undefined opcode
    task automatic run_model();
        acc_t               a0;
        word_t              x;
        ram_addr_t          ptr [4];
        ram_addr_t          adr;
        word_t              w;
        logic signed [31:0] prod;
        int                 pc;
        logic               done;
        a0   = '0;
        x    = '0;
        ptr  = '{default: '0};
        pc   = 0;
        done = 1'b0;
        for (int step = 0; step < RUN_LIMIT && !done; step++) begin
            w   = prog[pc];
            adr = ptr[w[11:10]];
            pc  = pc + 1;
            case (w[15:12])
                OP_NOP:  ;
                OP_LDAI: a0 = acc_t'($signed(w[7:0]));
                OP_SETX: x = word_t'($signed(w[7:0]));
                OP_SETR: ptr[w[11:10]] = w[7:0];
                OP_LDA:  a0 = acc_t'($signed(model_ram[adr]));
                OP_STA:  model_ram[adr] = a0[15:0];
                OP_MAC: begin
                    prod = $signed(x) * $signed(model_ram[adr]);
                    a0   = a0 + acc_t'(prod);
                end
                OP_OUT:  exp_outs.push_back(a0[15:0]);
                OP_GOTO: pc = int'(w[7:0]);
                default: done = 1'b1;
            endcase
            if (w[9] && (w[15:12] inside {OP_LDA, OP_STA, OP_MAC})) begin
                ptr[w[11:10]] = adr + 1'b1;
            end
        end
    endtask

    // One Wishbone classic access on the host port
    task automatic host_access(input logic we, input ram_addr_t adr, input word_t dat,
                               output word_t rdat);
        int n;
        @(posedge clk);
        #1;
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        n = 0;
        @(negedge clk);
        while (!host_rsp.ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        rdat = host_rsp.dat;
        @(posedge clk);
        #1;
        host_req = '0;
        if (n >= WAIT_LIMIT) begin
            $display("Host access to address %h never got an ack", adr);
            timeouts++;
        end
    endtask

    task automatic wait_fault();
        int n;
        n = 0;
        while (!fault && n < RUN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!fault) begin
            $display("Program never reached the undefined opcode");
            timeouts++;
        end
    endtask

    // OUT strobes against the model in program order
    always @(negedge clk) begin
        if (!reset && !pods_n) begin
            if (fault) begin
                $display("Output strobe seen after fault was raised");
                errors++;
            end else if (pulses < exp_outs.size()) begin
                check($sformatf("out_%0d", pulses), exp_outs[pulses], pbus_out);
            end else begin
                $display("Output strobe %0d has no matching OUT in the model", pulses);
                errors++;
            end
            pulses++;
        end
    end

    initial begin
        word_t rdat;
        word_t host_val;
        word_t d;
        imm_t  vals [4];
        imm_t  xv;
        clk       = 1'b0;
        reset     = 1'b1;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = 1'b0;
        host_req  = '0;
        errors    = 0;
        timeouts  = 0;
        pulses    = 0;
        rng       = 32'd63;

        for (int i = 0; i < 4; i++) begin
            rng     = xorshift32(rng);
            vals[i] = rng[7:0];
        end
        // Negative x so that some products come out negative
        rng      = xorshift32(rng);
        xv       = rng[7:0] | 8'h80;
        rng      = xorshift32(rng);
        host_val = rng[15:0];

        // Store four words at 0x10 with post-increment
        prog.push_back(encode(OP_SETR, 2'd0, 1'b0, 8'h10));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(encode(OP_LDAI, 2'd0, 1'b0, vals[i]));
            prog.push_back(encode(OP_STA, 2'd0, 1'b1, 8'h00));
        end
        // Dot product of x with the stored words
        prog.push_back(encode(OP_SETR, 2'd1, 1'b0, 8'h10));
        prog.push_back(encode(OP_SETX, 2'd0, 1'b0, xv));
        prog.push_back(encode(OP_LDAI, 2'd0, 1'b0, 8'h00));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(encode(OP_MAC, 2'd1, 1'b1, 8'h00));
        end
        prog.push_back(encode(OP_OUT, 2'd0, 1'b0, 8'h00));
        // Jump over an undefined word
        prog.push_back(encode(OP_GOTO, 2'd0, 1'b0, imm_t'(prog.size() + 2)));
        prog.push_back(16'hF000);
        prog.push_back(encode(OP_NOP, 2'd0, 1'b0, 8'h00));
        // Word written by the host before the core gets here
        prog.push_back(encode(OP_SETR, 2'd2, 1'b0, 8'h40));
        prog.push_back(encode(OP_LDA, 2'd2, 1'b0, 8'h00));
        prog.push_back(encode(OP_OUT, 2'd0, 1'b0, 8'h00));
        prog.push_back(16'hF000);

        for (int i = 0; i < `DSP_RAM_DEPTH; i++) begin
            model_ram[i] = '0;
        end
        model_ram[8'h40] = host_val;
        run_model();

        // ROM is loaded byte by byte while reset is held
        for (int i = 0; i < prog.size(); i++) begin
            for (int b = 0; b < 2; b++) begin
                @(posedge clk);
                #1;
                prog_we   = 1'b1;
                prog_addr = prog_addr_t'(2 * i + b);
                prog_data = (b == 1) ? prog[i][15:8] : prog[i][7:0];
            end
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        check("reset_pods_n", 32'd1, pods_n);
        check("reset_fault", 32'd0, fault);
        check("reset_host_ack", 32'd0, host_rsp.ack);

        host_access(1'b1, 8'h40, host_val, rdat);

        // Host traffic while the core runs
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    rng = xorshift32(rng);
                    d   = rng[15:0];
                    host_access(1'b1, ram_addr_t'(8'h80 + i), d, rdat);
                    host_access(1'b0, ram_addr_t'(8'h80 + i), 16'h0000, rdat);
                    check($sformatf("host_read_%0d", i), d, rdat);
                end
            end
            wait_fault();
        join

        // Quiet window after the fault
        repeat (20) @(negedge clk);
        check("fault_sticky", 32'd1, fault);
        check("out_count", exp_outs.size(), pulses);

        for (int i = 0; i < 4; i++) begin
            host_access(1'b0, ram_addr_t'(8'h10 + i), 16'h0000, rdat);
            check($sformatf("stored_%0d", i), model_ram[8'h10 + i], rdat);
        end

        finish_run();
    end

endmodule

//--- compile.f
+incdir+.
dsp_pkg.sv
dsp_rom.sv
dsp_seq.sv
dsp_ram_aau.sv
dsp_dau.sv
dsp_ram_arbiter.sv
dsp_ram.sv
dsp_core_top.sv
tb_dsp_core_assertions.sv
tb_dsp_core.sv

//--- Makefile
# Verilator simulation of the DSP core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run tb_dsp_core, pass or fail from $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_dsp_core -o tb_dsp_core
	./obj_dir/tb_dsp_core +verilator+error+limit+100000 | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
